// File: Bender.yml
package:
  name: stream_pack

sources:
  - include_dirs:
      - .
    files:
      - stream_pkg.sv
      - byte_packer.sv
      - word_fifo.sv
      - checksum_unpacker.sv
      - stream_pack_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_stream_pack_top.sv

// File: byte_packer.sv
// producer that gathers a byte stream into counted word beats.
`timescale 1ns/1ps
`include "stream_macros.svh"

module byte_packer (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   in_valid_i,
  input  stream_pkg::byte_beat_t in_beat_i,
  output logic                   in_ready_o,
  output logic                   word_valid_o,
  output stream_pkg::word_beat_t word_beat_o,
  input  logic                   word_ready_i
);

  localparam int LANES  = `STREAM_BYTES_PER_WORD;
  localparam int LANE_W = $clog2(LANES);

  logic [LANE_W-1:0] idx_q;      // next free lane.
  stream_pkg::word_t asm_q;      // bytes gathered so far.
  stream_pkg::word_t asm_next;   // gathered bytes plus incoming one.
  logic              closes;     // incoming byte completes a word.
  logic              in_fire;    // byte taken this cycle.
  logic              out_fire;   // word taken by the fifo.

  // merge the incoming byte into its lane.
  always_comb begin
    asm_next = asm_q;
    asm_next[idx_q*8 +: 8] = in_beat_i.data;          // lane from byte index.
    closes = (idx_q == LANES-1) || in_beat_i.last;    // full word or end of packet.
  end

  assign out_fire = word_valid_o && word_ready_i;

  // a held word blocks only the byte that would close the next word.
  assign in_ready_o = !word_valid_o || word_ready_i || !closes;
  assign in_fire    = in_valid_i && in_ready_o;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      idx_q        <= '0;
      word_valid_o <= 1'b0;
    end else begin
      if (in_fire) begin
        idx_q <= closes ? '0 : idx_q + 1'b1;   // restart lanes on close.
      end
      if (in_fire && closes) begin
        word_valid_o <= 1'b1;                  // new word in output register.
      end else if (out_fire) begin
        word_valid_o <= 1'b0;                  // drained, nothing behind it.
      end
    end
  end

  // assembly and output payload.
  always_ff @(posedge clk) begin
    if (in_fire) begin
      asm_q <= asm_next;
    end
    if (in_fire && closes) begin
      word_beat_o.data  <= asm_next;
      word_beat_o.count <= stream_pkg::byte_cnt_t'(idx_q) + 1'b1;   // lanes used.
      word_beat_o.last  <= in_beat_i.last;
    end
  end

endmodule

// File: checksum_unpacker.sv
// consumer that splits word beats into bytes and appends a packet sum byte.
`timescale 1ns/1ps
`include "stream_macros.svh"

module checksum_unpacker (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   word_valid_i,
  input  stream_pkg::word_beat_t word_beat_i,
  output logic                   word_ready_o,
  output logic                   out_valid_o,
  output stream_pkg::byte_beat_t out_beat_o,
  input  logic                   out_ready_i
);

  localparam int LANE_W = $clog2(`STREAM_BYTES_PER_WORD);

  stream_pkg::unpack_state_t state_q;
  stream_pkg::unpack_state_t state_d;
  stream_pkg::word_t         word_q;      // captured word.
  stream_pkg::byte_cnt_t     cnt_q;       // its valid lanes.
  logic                      last_q;      // word closes a packet.
  logic [LANE_W-1:0]         lane_q;      // lane being presented.
  stream_pkg::byte_t         sum_q;       // running packet sum.
  stream_pkg::byte_t         lane_byte;   // byte at current lane.
  logic                      final_lane;
  logic                      word_fire;
  logic                      out_fire;

  assign word_ready_o = (state_q == stream_pkg::st_idle);   // one word at a time.
  assign word_fire    = word_valid_i && word_ready_o;
  assign out_fire     = out_valid_o && out_ready_i;
  assign lane_byte    = word_q[lane_q*8 +: 8];
  assign final_lane   = (stream_pkg::byte_cnt_t'(lane_q) + 1'b1) == cnt_q;

  always_comb begin
    state_d         = state_q;
    out_valid_o     = 1'b0;
    out_beat_o.data = lane_byte;
    out_beat_o.last = 1'b0;                 // only the sum byte ends a packet.
    case (state_q)
      stream_pkg::st_idle: begin
        if (word_fire) begin
          state_d = stream_pkg::st_bytes;
        end
      end
      stream_pkg::st_bytes: begin
        out_valid_o = 1'b1;
        if (out_ready_i && final_lane) begin
          state_d = last_q ? stream_pkg::st_checksum : stream_pkg::st_idle;
        end
      end
      stream_pkg::st_checksum: begin
        out_valid_o     = 1'b1;
        out_beat_o.data = sum_q;
        out_beat_o.last = 1'b1;
        if (out_ready_i) begin
          state_d = stream_pkg::st_idle;
        end
      end
      default: state_d = stream_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state_q <= stream_pkg::st_idle;
      lane_q  <= '0;
      sum_q   <= '0;
    end else begin
      state_q <= state_d;
      if (word_fire) begin
        lane_q <= '0;                                  // start at byte 0.
      end else if (out_fire && state_q == stream_pkg::st_bytes) begin
        lane_q <= lane_q + 1'b1;
        sum_q  <= sum_q + lane_byte;                   // wraps modulo 256.
      end else if (out_fire && state_q == stream_pkg::st_checksum) begin
        sum_q <= '0;                                   // fresh sum per packet.
      end
    end
  end

  // word payload, held while its bytes go out.
  always_ff @(posedge clk) begin
    if (word_fire) begin
      word_q <= word_beat_i.data;
      cnt_q  <= word_beat_i.count;
      last_q <= word_beat_i.last;
    end
  end

endmodule

// File: project.f
+incdir+.
stream_pkg.sv
byte_packer.sv
word_fifo.sv
checksum_unpacker.sv
stream_pack_top.sv
tb_stream_pack_top.sv

// File: stream_macros.svh
// size macros for the byte stream packing path.
`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// default depth of the word fifo.
// must be a power of two and at least 2.
`define STREAM_FIFO_SLOTS 4

// bytes carried by one packed word.
// also sets the word and count widths.
`define STREAM_BYTES_PER_WORD 4

`endif

// File: stream_pack_top.sv
// top level joining byte packer, word fifo and checksum unpacker.
`timescale 1ns/1ps

module stream_pack_top (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   in_valid_i,
  input  stream_pkg::byte_beat_t in_beat_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output stream_pkg::byte_beat_t out_beat_o,
  input  logic                   out_ready_i
);

  logic                   pk_valid;   // packer to fifo.
  logic                   pk_ready;
  stream_pkg::word_beat_t pk_beat;
  logic                   ff_valid;   // fifo to unpacker.
  logic                   ff_ready;
  stream_pkg::word_beat_t ff_beat;

  byte_packer u_packer (
    .clk          (clk),
    .arst         (arst),
    .in_valid_i   (in_valid_i),
    .in_beat_i    (in_beat_i),
    .in_ready_o   (in_ready_o),
    .word_valid_o (pk_valid),
    .word_beat_o  (pk_beat),
    .word_ready_i (pk_ready)
  );

  // default depth from the size macros.
  word_fifo u_fifo (
    .clk        (clk),
    .arst       (arst),
    .wr_valid_i (pk_valid),
    .wr_beat_i  (pk_beat),
    .wr_ready_o (pk_ready),
    .rd_valid_o (ff_valid),
    .rd_beat_o  (ff_beat),
    .rd_ready_i (ff_ready)
  );

  checksum_unpacker u_unpacker (
    .clk          (clk),
    .arst         (arst),
    .word_valid_i (ff_valid),
    .word_beat_i  (ff_beat),
    .word_ready_o (ff_ready),
    .out_valid_o  (out_valid_o),
    .out_beat_o   (out_beat_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

// File: stream_pkg.sv
// vector typedefs, beat structs and unpacker state enum for the packing path.
`include "stream_macros.svh"

package stream_pkg;

  typedef logic [7:0] byte_t;                                    // one data byte.
  typedef logic [`STREAM_BYTES_PER_WORD*8-1:0] word_t;           // byte 0 in low bits.
  typedef logic [$clog2(`STREAM_BYTES_PER_WORD):0] byte_cnt_t;   // valid bytes, 1 to 4.

  // byte link beat, used at the top input and output.
  typedef struct packed {
    byte_t data;   // payload byte.
    logic  last;   // final byte of packet.
  } byte_beat_t;

  // word link beat between packer, fifo and unpacker.
  typedef struct packed {
    word_t     data;    // packed bytes.
    byte_cnt_t count;   // valid lanes from byte 0 up.
    logic      last;    // word closes its packet.
  } word_beat_t;

  // unpacker FSM states.
  typedef enum logic [1:0] {
    st_idle,       // waiting for a word.
    st_bytes,      // emitting counted lanes.
    st_checksum    // emitting the packet sum.
  } unpack_state_t;

endpackage

// File: tb_stream_pack_top.sv
// testbench for stream_pack_top with packet table, stall modes, reference queue and checks.
`timescale 1ns/1ps

module tb_stream_pack_top;

  localparam int MODE_ALWAYS = 0;   // sink always ready.
  localparam int MODE_RANDOM = 1;   // sink ready on a coin flip.
  localparam int MODE_BURST  = 2;   // long low stretches with short high windows.
  localparam int N_PKTS      = 8;

  logic                   clk;
  logic                   arst;
  logic                   in_valid_i;
  stream_pkg::byte_beat_t in_beat_i;
  logic                   in_ready_o;
  logic                   out_valid_o;
  stream_pkg::byte_beat_t out_beat_o;
  logic                   out_ready_i;

  // packet table with length and sink mode per entry.
  int pkt_len  [N_PKTS] = '{1, 2, 3, 4, 5, 8, 11, 1};
  int pkt_mode [N_PKTS] = '{MODE_ALWAYS, MODE_RANDOM, MODE_ALWAYS, MODE_RANDOM,
                            MODE_BURST, MODE_BURST, MODE_BURST, MODE_RANDOM};

  integer                 seed = 32'h8e6e_43db;
  int                     err_cnt = 0;
  int                     cycle_cnt = 0;
  int                     sink_mode = MODE_ALWAYS;
  int                     burst_cnt = 0;
  logic [31:0]            sink_rnd;
  logic                   seen_stall = 1'b0;   // in_ready_o seen low with a byte waiting.
  stream_pkg::byte_beat_t exp_q [$];           // expected output stream.
  stream_pkg::byte_beat_t mon_exp;

  stream_pack_top uut (
    .clk         (clk),
    .arst        (arst),
    .in_valid_i  (in_valid_i),
    .in_beat_i   (in_beat_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_beat_o  (out_beat_o),
    .out_ready_i (out_ready_i)
  );

  always #4 clk = ~clk;   // 8 ns period.

  // compare and log a mismatch.
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  // present one byte and return at the edge where it transfers.
  task automatic send_byte(input stream_pkg::byte_t d, input logic l);
    in_valid_i     <= 1'b1;
    in_beat_i.data <= d;
    in_beat_i.last <= l;
    @(posedge clk);
    while (!in_ready_o) begin
      @(posedge clk);   // held until taken.
    end
  endtask

  // total bytes over the whole table.
  function automatic int table_bytes();
    int total;
    total = 0;
    for (int i = 0; i < N_PKTS; i++) begin
      total += pkt_len[i];
    end
    return total;
  endfunction

  // sink ready pattern follows the mode of the current packet.
  always @(posedge clk) begin
    sink_rnd = $random(seed);
    case (sink_mode)
      MODE_ALWAYS: out_ready_i <= 1'b1;
      MODE_RANDOM: out_ready_i <= sink_rnd[0];
      default:     out_ready_i <= (burst_cnt % 44) >= 40;   // 40 cycles low then 4 high.
    endcase
    if (sink_mode == MODE_BURST) begin
      burst_cnt <= burst_cnt + 1;
    end
  end

  // output monitor against the reference queue.
  always @(posedge clk) begin
    if (!arst && in_valid_i && !in_ready_o) begin
      seen_stall <= 1'b1;
    end
    if (!arst && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("output byte 0x%0h appeared with nothing left to expect", out_beat_o.data);
        err_cnt++;
      end else begin
        mon_exp = exp_q.pop_front();
        check_value("out_beat_o.data", out_beat_o.data, mon_exp.data);
        check_value("out_beat_o.last", out_beat_o.last, mon_exp.last);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // watchdog at 40 cycles per table byte plus slack.
  initial begin : watchdog
    int limit;
    limit = 40 * table_bytes() + 200;
    while (cycle_cnt < limit) begin
      @(posedge clk);
    end
    $display("timeout after %0d cycles with %0d bytes still expected", limit, exp_q.size());
    $display("errors: %0d", err_cnt);
    $display("tests failed");
    $finish;
  end

  initial begin : stimulus
    stream_pkg::byte_t      pkt_bytes [N_PKTS][16];
    stream_pkg::byte_beat_t exp_beat;
    int                     sum;
    clk         = 1'b0;
    arst        = 1'b1;
    in_valid_i  = 1'b0;
    in_beat_i   = '0;
    out_ready_i = 1'b0;

    // packet bytes drawn before the first edge.
    for (int i = 0; i < N_PKTS; i++) begin
      for (int j = 0; j < pkt_len[i]; j++) begin
        pkt_bytes[i][j] = $random(seed);
      end
    end

    // output stays quiet through the 4 reset cycles.
    repeat (4) begin
      @(posedge clk);
      check_value("out_valid_o", out_valid_o, 1'b0);
    end
    arst <= 1'b0;
    @(posedge clk);
    check_value("in_ready_o", in_ready_o, 1'b1);   // packer empty after reset.
    check_value("out_valid_o", out_valid_o, 1'b0);

    for (int i = 0; i < N_PKTS; i++) begin
      sink_mode <= pkt_mode[i];
      sum = 0;
      // expected stream goes first so the monitor never runs ahead.
      for (int j = 0; j < pkt_len[i]; j++) begin
        sum          += pkt_bytes[i][j];
        exp_beat.data = pkt_bytes[i][j];
        exp_beat.last = 1'b0;
        exp_q.push_back(exp_beat);
      end
      exp_beat.data = sum % 256;   // byte sum closes the packet.
      exp_beat.last = 1'b1;
      exp_q.push_back(exp_beat);
      for (int j = 0; j < pkt_len[i]; j++) begin
        send_byte(pkt_bytes[i][j], j == pkt_len[i] - 1);
      end
    end
    in_valid_i <= 1'b0;

    // drain and then watch for stray bytes.
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    sink_mode <= MODE_ALWAYS;
    repeat (20) @(posedge clk);

    check_value("out_valid_o", out_valid_o, 1'b0);          // nothing left in the path.
    check_value("in_ready_o low seen", seen_stall, 1'b1);   // burst packets fill the fifo.

    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: word_fifo.sv
// pointer-based word fifo with valid/ready on write and read sides.
`timescale 1ns/1ps
`include "stream_macros.svh"

module word_fifo #(
  parameter int SLOTS = `STREAM_FIFO_SLOTS
) (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   wr_valid_i,
  input  stream_pkg::word_beat_t wr_beat_i,
  output logic                   wr_ready_o,
  output logic                   rd_valid_o,
  output stream_pkg::word_beat_t rd_beat_o,
  input  logic                   rd_ready_i
);

  localparam int ADDR_W = $clog2(SLOTS);

  stream_pkg::word_beat_t [SLOTS-1:0] mem;   // beat storage.
  logic [ADDR_W:0] wr_ptr;                   // msb is the wrap bit.
  logic [ADDR_W:0] rd_ptr;                   // msb is the wrap bit.
  logic            full;
  logic            empty;
  logic            wr_fire;
  logic            rd_fire;

  // same address on both pointers; wrap bits tell full from empty.
  always_comb begin
    empty = (wr_ptr == rd_ptr);
    full  = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]) &&
            (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);
  end

  assign wr_ready_o = !full;
  assign rd_valid_o = !empty;
  assign wr_fire    = wr_valid_i && wr_ready_o;
  assign rd_fire    = rd_valid_o && rd_ready_i;

  // read port falls through from storage.
  assign rd_beat_o = mem[rd_ptr[ADDR_W-1:0]];

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      mem    <= '0;
    end else begin
      if (wr_fire) begin
        mem[wr_ptr[ADDR_W-1:0]] <= wr_beat_i;   // visible on the next cycle.
        wr_ptr                  <= wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule
